// File: common/noc_cfg.svh
// Build-time sizes and the default system address map of the memory fabric.
// Include this wherever bus widths, the tile count or SAM ranges are needed.
// A different memory map only needs the base and span macros changed.

`ifndef NOC_CFG_SVH
`define NOC_CFG_SVH

// Bus widths of the Wishbone port and the links
`define NOC_ADDR_W 32
`define NOC_DATA_W 32

// Number of endpoint tiles behind the fabric
`define NOC_NUM_TILES 4

// Words of storage in each tile
`define NOC_MEM_WORDS 256

// Default SAM, one range per tile
`define NOC_SAM_BASE_0 32'h0000_0000
`define NOC_SAM_BASE_1 32'h0000_1000
`define NOC_SAM_BASE_2 32'h0000_2000
`define NOC_SAM_BASE_3 32'h0000_3000

// Length in bytes of every tile range
// 256 words of 4 bytes each
`define NOC_SAM_SPAN 32'h0000_0400

`endif

// File: common/noc_pkg.sv
// Shared types of the memory fabric: addresses, IDs, SAM rules and link flits.
// Every fabric module takes these through a wildcard import in its header.

`default_nettype none

`include "noc_cfg.svh"

package noc_pkg;

  // Endpoint ID, wide enough to name every tile
  typedef logic [$clog2(`NOC_NUM_TILES)-1:0] id_t;

  typedef logic [`NOC_ADDR_W-1:0]     addr_t;
  typedef logic [`NOC_DATA_W-1:0]     data_t;
  typedef logic [`NOC_DATA_W/8-1:0]   be_t;

  // Word index inside one tile memory
  typedef logic [$clog2(`NOC_MEM_WORDS)-1:0] word_idx_t;

  // One SAM entry, end address is exclusive
  typedef struct packed {
    id_t   idx;
    addr_t start_addr;
    addr_t end_addr;
  } addr_rule_t;

  // Request flit toward a tile
  typedef struct packed {
    id_t       dst_id;
    logic      we;
    be_t       be;
    word_idx_t idx;
    data_t     wdata;
  } req_flit_t;

  // Response flit, carries the new word on writes
  typedef struct packed {
    data_t rdata;
  } rsp_flit_t;

  // Default address map built from the cfg ranges
  localparam addr_rule_t [`NOC_NUM_TILES-1:0] DefaultSam = '{
    0: '{idx: id_t'(0), start_addr: `NOC_SAM_BASE_0, end_addr: `NOC_SAM_BASE_0 + `NOC_SAM_SPAN},
    1: '{idx: id_t'(1), start_addr: `NOC_SAM_BASE_1, end_addr: `NOC_SAM_BASE_1 + `NOC_SAM_SPAN},
    2: '{idx: id_t'(2), start_addr: `NOC_SAM_BASE_2, end_addr: `NOC_SAM_BASE_2 + `NOC_SAM_SPAN},
    3: '{idx: id_t'(3), start_addr: `NOC_SAM_BASE_3, end_addr: `NOC_SAM_BASE_3 + `NOC_SAM_SPAN}
  };

endpackage

`default_nettype wire

// File: common/noc_link_if.sv
// Request/response link between ingress, tiles and response drain.
// Both channels are valid/ready; payload holds while valid waits for ready.

`timescale 1ns/1ps
`default_nettype none

interface noc_link_if import noc_pkg::*; ();

  // Request channel, ingress toward tile
  logic      req_valid;
  logic      req_ready;
  req_flit_t req;

  // Response channel, tile toward drain
  logic      rsp_valid;
  logic      rsp_ready;
  rsp_flit_t rsp;

  // Request source, the Wishbone ingress
  modport src (
    output req_valid,
    output req,
    input  req_ready
  );

  // Endpoint side, takes requests and sources responses
  modport tile (
    input  req_valid,
    input  req,
    output req_ready,
    output rsp_valid,
    output rsp,
    input  rsp_ready
  );

  // Response sink
  modport drain (
    input  rsp_valid,
    input  rsp,
    output rsp_ready
  );

endinterface

`default_nettype wire

// File: rtl/noc_id_translation.sv
// Address to endpoint ID lookup through the system address map.
// Purely combinational; the first rule holding the address wins.
// Unmatched addresses raise dec_error_o and return ID zero.

`timescale 1ns/1ps
`default_nettype none

`include "noc_cfg.svh"

module noc_id_translation import noc_pkg::*; #(
  // Address map, half-open ranges tagged with an endpoint ID
  parameter addr_rule_t [`NOC_NUM_TILES-1:0] Sam = DefaultSam
) (
  input  addr_t addr_i,
  output id_t   id_o,
  output logic  dec_error_o
);

  localparam int unsigned NumRules = `NOC_NUM_TILES;

  // Per-rule hit flags
  logic [NumRules-1:0] rule_hit;

  // Range compare for every rule in parallel
  for (genvar r = 0; r < NumRules; r++) begin : gen_rule_cmp
    assign rule_hit[r] = (addr_i >= Sam[r].start_addr) && (addr_i < Sam[r].end_addr);
  end

  // Priority pick
  always_comb begin
    id_o        = '0;
    dec_error_o = 1'b1;
    for (int i = 0; i < NumRules; i++) begin
      // Only the lowest matching rule is taken
      if (dec_error_o && rule_hit[i]) begin
        id_o        = Sam[i].idx;
        dec_error_o = 1'b0;
      end
    end
  end

endmodule

`default_nettype wire

// File: ingress/noc_wb_ingress.sv
// Wishbone classic slave front end of the fabric.
// Decodes the address through the SAM, sends one flit to the chosen tile,
// waits for the merged response and ends the cycle with ack_o or err_o.

`timescale 1ns/1ps
`default_nettype none

`include "noc_cfg.svh"

module noc_wb_ingress import noc_pkg::*; #(
  parameter addr_rule_t [`NOC_NUM_TILES-1:0] Sam = DefaultSam
) (
  input  logic      clk_i,
  input  logic      rst_n_i,
  // Wishbone classic slave
  input  logic      cyc_i,
  input  logic      stb_i,
  input  logic      we_i,
  input  addr_t     adr_i,
  input  be_t       sel_i,
  input  data_t     dat_i,
  output data_t     dat_o,
  output logic      ack_o,
  output logic      err_o,
  // One request link per tile
  noc_link_if.src   link_o [`NOC_NUM_TILES],
  // Merged response from the drain
  noc_link_if.drain rsp_i
);

  localparam int unsigned NumTiles = `NOC_NUM_TILES;
  localparam int unsigned ByteOffW = $clog2(`NOC_DATA_W / 8);

  typedef enum logic [1:0] {StIdle, StSend, StWait, StDone} state_e;

  state_e                state_q;
  id_t                   dec_id;
  logic                  dec_error;
  req_flit_t             flit_q;
  logic                  req_valid_q;
  data_t                 dat_q;
  logic                  ack_q;
  logic                  err_q;
  logic [NumTiles-1:0]   tile_ready;

  noc_id_translation #(
    .Sam ( Sam )
  ) i_id_translation (
    .addr_i      ( adr_i     ),
    .id_o        ( dec_id    ),
    .dec_error_o ( dec_error )
  );

  // Steer valid to the decoded tile only; every link sees the same flit
  for (genvar g = 0; g < NumTiles; g++) begin : gen_link
    assign link_o[g].req_valid = req_valid_q && (flit_q.dst_id == id_t'(g));
    assign link_o[g].req       = flit_q;
    assign tile_ready[g]       = link_o[g].req_ready;
  end

  // Single response ready, only while waiting
  assign rsp_i.rsp_ready = (state_q == StWait);

  assign dat_o = dat_q;
  assign ack_o = ack_q;
  assign err_o = err_q;

  // Cycle FSM
  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      state_q     <= StIdle;
      req_valid_q <= 1'b0;
      ack_q       <= 1'b0;
      err_q       <= 1'b0;
    end else begin
      case (state_q)
        StIdle: begin
          if (cyc_i && stb_i) begin
            // Unmapped address never reaches a link
            if (dec_error) begin
              err_q   <= 1'b1;
              state_q <= StDone;
            end else begin
              req_valid_q <= 1'b1;
              state_q     <= StSend;
            end
          end
        end
        StSend: begin
          // Hold until the target tile takes the flit
          if (tile_ready[flit_q.dst_id]) begin
            req_valid_q <= 1'b0;
            state_q     <= StWait;
          end
        end
        StWait: begin
          if (rsp_i.rsp_valid) begin
            ack_q   <= 1'b1;
            state_q <= StDone;
          end
        end
        StDone: begin
          // One-clock ack or err pulse
          ack_q   <= 1'b0;
          err_q   <= 1'b0;
          state_q <= StIdle;
        end
        default: state_q <= StIdle;
      endcase
    end
  end

  // Flit and read data capture
  always_ff @(posedge clk_i) begin
    if (state_q == StIdle && cyc_i && stb_i) begin
      flit_q.dst_id <= dec_id;
      flit_q.we     <= we_i;
      flit_q.be     <= sel_i;
      flit_q.idx    <= adr_i[ByteOffW +: $bits(word_idx_t)];
      flit_q.wdata  <= dat_i;
    end
    if (state_q == StWait && rsp_i.rsp_valid) begin
      dat_q <= rsp_i.rsp.rdata;
    end
  end

endmodule

`default_nettype wire

// File: tile/noc_mem_tile.sv
// Memory endpoint tile with a single link target port.
// Holds a word memory with byte-enable writes and a one-entry response
// register; new requests stall while that register is full.

`timescale 1ns/1ps
`default_nettype none

`include "noc_cfg.svh"

module noc_mem_tile import noc_pkg::*; (
  input  logic     clk_i,
  input  logic     rst_n_i,
  noc_link_if.tile link
);

  localparam int unsigned NumBytes = $bits(be_t);

  // Word storage
  data_t mem_q [`NOC_MEM_WORDS];

  logic  rsp_valid_q;
  data_t rsp_data_q;
  logic  req_fire;
  data_t old_word;
  data_t merged_word;

  // Accept only with an empty response slot
  assign link.req_ready = !rsp_valid_q;
  assign req_fire       = link.req_valid && link.req_ready;

  assign link.rsp_valid = rsp_valid_q;
  assign link.rsp.rdata = rsp_data_q;

  assign old_word = mem_q[link.req.idx];

  // Byte merge of write data into the stored word
  always_comb begin
    merged_word = old_word;
    for (int b = 0; b < NumBytes; b++) begin
      if (link.req.be[b]) begin
        merged_word[8*b +: 8] = link.req.wdata[8*b +: 8];
      end
    end
  end

  // Memory write and response payload
  always_ff @(posedge clk_i) begin
    if (req_fire) begin
      if (link.req.we) begin
        mem_q[link.req.idx] <= merged_word;
        // Writes echo the new word
        rsp_data_q          <= merged_word;
      end else begin
        rsp_data_q <= old_word;
      end
    end
  end

  // Response slot state
  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      rsp_valid_q <= 1'b0;
    end else if (req_fire) begin
      rsp_valid_q <= 1'b1;
    end else if (link.rsp_ready) begin
      // Drained this cycle
      rsp_valid_q <= 1'b0;
    end
  end

endmodule

`default_nettype wire

// File: rtl/noc_rsp_drain.sv
// Round-robin merge of tile responses onto one link toward the ingress.
// Grant is combinational and locked while the ingress stalls; the priority
// pointer moves past the granted tile once its transfer completes.

`timescale 1ns/1ps
`default_nettype none

`include "noc_cfg.svh"

module noc_rsp_drain import noc_pkg::*; (
  input  logic      clk_i,
  input  logic      rst_n_i,
  noc_link_if.drain tiles_i [`NOC_NUM_TILES],
  noc_link_if.tile  out_o
);

  localparam int unsigned NumTiles = `NOC_NUM_TILES;

  logic [NumTiles-1:0] tile_valid;
  rsp_flit_t           tile_rsp [NumTiles];
  id_t                 ptr_q;
  id_t                 rr_idx;
  id_t                 cand;
  id_t                 sel_idx;
  id_t                 lock_idx_q;
  logic                lock_q;
  logic                found;

  // Gather tile responses and give ready only to the granted one
  for (genvar g = 0; g < NumTiles; g++) begin : gen_tile
    assign tile_valid[g]       = tiles_i[g].rsp_valid;
    assign tile_rsp[g]         = tiles_i[g].rsp;
    assign tiles_i[g].rsp_ready = out_o.rsp_ready && (|tile_valid) && (sel_idx == id_t'(g));
  end

  // First valid tile at or after the pointer
  always_comb begin
    rr_idx = ptr_q;
    found  = 1'b0;
    for (int i = 0; i < NumTiles; i++) begin
      cand = id_t'(ptr_q + i);
      if (!found && tile_valid[cand]) begin
        rr_idx = cand;
        found  = 1'b1;
      end
    end
  end

  // Keep a stalled grant until it transfers
  assign sel_idx = lock_q ? lock_idx_q : rr_idx;

  assign out_o.rsp_valid = |tile_valid;
  assign out_o.rsp       = tile_rsp[sel_idx];

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      ptr_q      <= '0;
      lock_q     <= 1'b0;
      lock_idx_q <= '0;
    end else begin
      lock_q     <= out_o.rsp_valid && !out_o.rsp_ready;
      lock_idx_q <= sel_idx;
      if (out_o.rsp_valid && out_o.rsp_ready) begin
        ptr_q <= id_t'(sel_idx + 1);
      end
    end
  end

endmodule

`default_nettype wire

// File: rtl/noc_fabric_top.sv
// Top level of the memory fabric with plain Wishbone classic slave ports.
// Wires the ingress, the tile array and the response drain together.
// Pass a different Sam to remap the tiles.

`timescale 1ns/1ps
`default_nettype none

`include "noc_cfg.svh"

module noc_fabric_top import noc_pkg::*; #(
  parameter addr_rule_t [`NOC_NUM_TILES-1:0] Sam = DefaultSam
) (
  input  logic  clk_i,
  input  logic  rst_n_i,
  input  logic  cyc_i,
  input  logic  stb_i,
  input  logic  we_i,
  input  addr_t adr_i,
  input  be_t   sel_i,
  input  data_t dat_i,
  output data_t dat_o,
  output logic  ack_o,
  output logic  err_o
);

  // One link per tile, plus the merged response link
  noc_link_if tile_link [`NOC_NUM_TILES] ();
  noc_link_if drain_link ();

  noc_wb_ingress #(
    .Sam ( Sam )
  ) i_ingress (
    .clk_i   ( clk_i      ),
    .rst_n_i ( rst_n_i    ),
    .cyc_i   ( cyc_i      ),
    .stb_i   ( stb_i      ),
    .we_i    ( we_i       ),
    .adr_i   ( adr_i      ),
    .sel_i   ( sel_i      ),
    .dat_i   ( dat_i      ),
    .dat_o   ( dat_o      ),
    .ack_o   ( ack_o      ),
    .err_o   ( err_o      ),
    .link_o  ( tile_link  ),
    .rsp_i   ( drain_link )
  );

  // Endpoint tiles
  for (genvar t = 0; t < `NOC_NUM_TILES; t++) begin : gen_tile
    noc_mem_tile i_tile (
      .clk_i   ( clk_i        ),
      .rst_n_i ( rst_n_i      ),
      .link    ( tile_link[t] )
    );
  end

  noc_rsp_drain i_drain (
    .clk_i   ( clk_i      ),
    .rst_n_i ( rst_n_i    ),
    .tiles_i ( tile_link  ),
    .out_o   ( drain_link )
  );

endmodule

`default_nettype wire

// File: verif/tb_noc_fabric.sv
// Testbench for the memory fabric behind its Wishbone classic slave port.
// Runs a directed vector table, a full memory sweep and an LCG-driven random phase,
// and checks every response against a reference model of the four tile memories.

`timescale 1ns/1ps
`default_nettype none

`include "noc_cfg.svh"

module tb_noc_fabric import noc_pkg::*; ();

  typedef struct {
    string name;
    logic  we;
    addr_t adr;
    be_t   sel;
    data_t wdata;
    logic  exp_err;
    data_t exp_data;
  } vec_t;

  logic  clk;
  logic  rst_n;
  logic  cyc;
  logic  stb;
  logic  we;
  addr_t adr;
  be_t   sel;
  data_t wdat;
  data_t rdat;
  logic  ack;
  logic  err;

  // Reference model, indexed by SAM rule and word index
  data_t      model [`NOC_NUM_TILES][`NOC_MEM_WORDS];
  vec_t       vecs [$];
  logic [31:0] rnd;

  noc_fabric_top DUT (
    .clk_i   ( clk   ),
    .rst_n_i ( rst_n ),
    .cyc_i   ( cyc   ),
    .stb_i   ( stb   ),
    .we_i    ( we    ),
    .adr_i   ( adr   ),
    .sel_i   ( sel   ),
    .dat_i   ( wdat  ),
    .dat_o   ( rdat  ),
    .ack_o   ( ack   ),
    .err_o   ( err   )
  );

  initial begin
    clk = 1'b0;
    forever #10 clk = ~clk;
  end

  function automatic logic [31:0] next_rand(input logic [31:0] s);
    return s * 32'd1664525 + 32'd1013904223;
  endfunction

  function automatic addr_t tile_base(input int t);
    case (t)
      0: return `NOC_SAM_BASE_0;
      1: return `NOC_SAM_BASE_1;
      2: return `NOC_SAM_BASE_2;
      default: return `NOC_SAM_BASE_3;
    endcase
  endfunction

  // Half-open range search, first hit wins
  function automatic logic lookup_tile(input addr_t a, output id_t t);
    lookup_tile = 1'b0;
    t = '0;
    for (int i = 0; i < `NOC_NUM_TILES; i++) begin
      if (!lookup_tile && a >= tile_base(i) && a < tile_base(i) + `NOC_SAM_SPAN) begin
        t = id_t'(i);
        lookup_tile = 1'b1;
      end
    end
  endfunction

  function automatic data_t merge_bytes(input data_t old_w, input data_t new_w, input be_t s);
    merge_bytes = old_w;
    for (int b = 0; b < $bits(be_t); b++) begin
      if (s[b]) merge_bytes[8*b +: 8] = new_w[8*b +: 8];
    end
  endfunction

  // Initial contents, unique per address
  function automatic data_t fill_word(input addr_t a);
    return (a * 32'h9E37_79B1) ^ 32'h5A5A_C3C3;
  endfunction

  // Vector whose expectation comes from the model
  function automatic vec_t model_vec(input string name, input logic w, input addr_t a,
                                     input be_t s, input data_t d);
    vec_t v;
    id_t  t;
    v.name = name;
    v.we = w;
    v.adr = a;
    v.sel = s;
    v.wdata = d;
    v.exp_err = !lookup_tile(a, t);
    v.exp_data = w ? merge_bytes(model[t][a[9:2]], d, s) : model[t][a[9:2]];
    return v;
  endfunction

  task automatic fail_run();
    $display("Simulation failed");
    $fatal(1);
  endtask

  task automatic check_data(input string name, input data_t exp_v, input data_t act_v);
    if (act_v !== exp_v) begin
      $display("ERR %s: expected %h, actual %h", name, exp_v, act_v);
      fail_run();
    end
  endtask

  task automatic check_err(input string name, input logic exp_v, input logic act_v);
    if (act_v !== exp_v) begin
      $display("ERR %s: expected err %b, actual err %b", name, exp_v, act_v);
      fail_run();
    end
  endtask

  task automatic add_vec(input string name, input logic w, input addr_t a, input be_t s,
                         input data_t d, input logic ee, input data_t ed);
    vec_t v;
    v.name = name;
    v.we = w;
    v.adr = a;
    v.sel = s;
    v.wdata = d;
    v.exp_err = ee;
    v.exp_data = ed;
    vecs.push_back(v);
  endtask

  // One classic cycle, ends on ack or err
  task automatic wb_cycle(input vec_t v, output data_t rd, output logic e);
    int cnt;
    @(posedge clk);
    #2;
    cyc = 1'b1;
    stb = 1'b1;
    we = v.we;
    adr = v.adr;
    sel = v.sel;
    wdat = v.wdata;
    cnt = 0;
    while (!(ack || err) && cnt < 50) begin
      @(posedge clk);
      #1;
      cnt++;
    end
    if (!(ack || err)) begin
      $display("Timeout: ack_o or err_o never came for %s", v.name);
      fail_run();
    end
    if (ack && err) begin
      $display("Both ack_o and err_o were high in %s", v.name);
      fail_run();
    end
    rd = rdat;
    e = err;
    #1;
    cyc = 1'b0;
    stb = 1'b0;
    we = 1'b0;
  endtask

  task automatic run_vec(input vec_t v);
    data_t rd;
    logic  e;
    logic  hit;
    id_t   t;
    wb_cycle(v, rd, e);
    check_err(v.name, v.exp_err, e);
    hit = lookup_tile(v.adr, t);
    if (!v.exp_err) check_data(v.name, v.exp_data, rd);
    // Refused writes leave the model alone
    if (hit && v.we) model[t][v.adr[9:2]] = merge_bytes(model[t][v.adr[9:2]], v.wdata, v.sel);
  endtask

  initial begin
    cyc = 1'b0;
    stb = 1'b0;
    we = 1'b0;
    adr = '0;
    sel = '0;
    wdat = '0;
    rst_n = 1'b0;
    rnd = 32'h1bb2;
    repeat (2) @(posedge clk);
    #2 rst_n = 1'b1;

    // Quiet bus after reset
    repeat (10) begin
      @(posedge clk);
      #1;
      if (ack || err) begin
        $display("ack_o or err_o went high with no bus cycle issued");
        fail_run();
      end
    end

    // Preload every word so later reads are defined
    for (int t = 0; t < `NOC_NUM_TILES; t++) begin
      for (int i = 0; i < `NOC_MEM_WORDS; i++) begin
        run_vec(model_vec($sformatf("fill_%0d_%0d", t, i), 1'b1, tile_base(t) + 4 * i,
                          4'hF, fill_word(tile_base(t) + 4 * i)));
      end
    end

    // First and last word of each tile
    add_vec("wr_t0_first", 1'b1, 32'h0000, 4'hF, 32'h0A00_0001, 1'b0, 32'h0A00_0001);
    add_vec("wr_t0_last",  1'b1, 32'h03FC, 4'hF, 32'h0A00_03FF, 1'b0, 32'h0A00_03FF);
    add_vec("wr_t1_first", 1'b1, 32'h1000, 4'hF, 32'h1B11_0001, 1'b0, 32'h1B11_0001);
    add_vec("wr_t1_last",  1'b1, 32'h13FC, 4'hF, 32'h1B11_03FF, 1'b0, 32'h1B11_03FF);
    add_vec("wr_t2_first", 1'b1, 32'h2000, 4'hF, 32'h2C22_0001, 1'b0, 32'h2C22_0001);
    add_vec("wr_t2_last",  1'b1, 32'h23FC, 4'hF, 32'h2C22_03FF, 1'b0, 32'h2C22_03FF);
    add_vec("wr_t3_first", 1'b1, 32'h3000, 4'hF, 32'h3D33_0001, 1'b0, 32'h3D33_0001);
    add_vec("wr_t3_last",  1'b1, 32'h33FC, 4'hF, 32'h3D33_03FF, 1'b0, 32'h3D33_03FF);
    add_vec("rd_t0_first", 1'b0, 32'h0000, 4'hF, 32'h0, 1'b0, 32'h0A00_0001);
    add_vec("rd_t0_last",  1'b0, 32'h03FC, 4'hF, 32'h0, 1'b0, 32'h0A00_03FF);
    add_vec("rd_t1_first", 1'b0, 32'h1000, 4'hF, 32'h0, 1'b0, 32'h1B11_0001);
    add_vec("rd_t1_last",  1'b0, 32'h13FC, 4'hF, 32'h0, 1'b0, 32'h1B11_03FF);
    add_vec("rd_t2_first", 1'b0, 32'h2000, 4'hF, 32'h0, 1'b0, 32'h2C22_0001);
    add_vec("rd_t2_last",  1'b0, 32'h23FC, 4'hF, 32'h0, 1'b0, 32'h2C22_03FF);
    add_vec("rd_t3_first", 1'b0, 32'h3000, 4'hF, 32'h0, 1'b0, 32'h3D33_0001);
    add_vec("rd_t3_last",  1'b0, 32'h33FC, 4'hF, 32'h0, 1'b0, 32'h3D33_03FF);
    // Byte-enable merges
    add_vec("wr_t1_base",  1'b1, 32'h1014, 4'hF, 32'h1122_3344, 1'b0, 32'h1122_3344);
    add_vec("wr_t1_part",  1'b1, 32'h1014, 4'h5, 32'hAABB_CCDD, 1'b0, 32'h11BB_33DD);
    add_vec("rd_t1_part",  1'b0, 32'h1014, 4'hF, 32'h0, 1'b0, 32'h11BB_33DD);
    add_vec("wr_t2_base",  1'b1, 32'h2020, 4'hF, 32'hCAFE_F00D, 1'b0, 32'hCAFE_F00D);
    add_vec("wr_t2_part",  1'b1, 32'h2020, 4'hC, 32'h1234_5678, 1'b0, 32'h1234_F00D);
    add_vec("rd_t2_part",  1'b0, 32'h2020, 4'hF, 32'h0, 1'b0, 32'h1234_F00D);
    // Unmapped addresses
    add_vec("err_hole_0",  1'b0, 32'h0000_0400, 4'hF, 32'h0, 1'b1, 32'h0);
    add_vec("err_hole_3",  1'b1, 32'h0000_3400, 4'hF, 32'hDEAD_BEEF, 1'b1, 32'h0);
    add_vec("err_high",    1'b1, 32'hFFFF_0000, 4'hF, 32'hDEAD_BEEF, 1'b1, 32'h0);
    foreach (vecs[i]) run_vec(vecs[i]);

    // Refused writes must not have touched any tile
    for (int t = 0; t < `NOC_NUM_TILES; t++) begin
      for (int i = 0; i < `NOC_MEM_WORDS; i++) begin
        run_vec(model_vec($sformatf("sweep_%0d_%0d", t, i), 1'b0, tile_base(t) + 4 * i,
                          4'hF, 32'h0));
      end
    end

    // Random mix, about one in eight lands in a hole
    for (int n = 0; n < 200; n++) begin
      addr_t a;
      rnd = next_rand(rnd);
      a = tile_base(rnd[23:22]) + {rnd[31:24], 2'b00};
      if (rnd[20:18] == 3'b000) a = a + `NOC_SAM_SPAN;
      run_vec(model_vec($sformatf("rand_%0d", n), rnd[21], a, rnd[17:14], next_rand(rnd)));
    end

    $display("Simulation passed");
    $finish;
  end

endmodule

`default_nettype wire

// File: list.f
+incdir+common
common/noc_pkg.sv
common/noc_link_if.sv
rtl/noc_id_translation.sv
ingress/noc_wb_ingress.sv
tile/noc_mem_tile.sv
rtl/noc_rsp_drain.sv
rtl/noc_fabric_top.sv
verif/tb_noc_fabric.sv

// File: Bender.yml
package:
  name: noc_fabric

export_include_dirs:
  - common

sources:
  - common/noc_pkg.sv
  - common/noc_link_if.sv
  - rtl/noc_id_translation.sv
  - ingress/noc_wb_ingress.sv
  - tile/noc_mem_tile.sv
  - rtl/noc_rsp_drain.sv
  - rtl/noc_fabric_top.sv
  - target: test
    files:
      - verif/tb_noc_fabric.sv
